/* hw/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regIdx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Major opcodes of the supported subset
  localparam opcode_t OpReg = 7'b0110011;
  localparam opcode_t OpImm = 7'b0010011;
  localparam opcode_t OpLoad = 7'b0000011;
  localparam opcode_t OpStore = 7'b0100011;
  localparam opcode_t OpBranch = 7'b1100011;

  localparam funct3_t F3AddSub = 3'b000;
  localparam funct3_t F3Slt = 3'b010;
  localparam funct3_t F3Xor = 3'b100;
  localparam funct3_t F3Or = 3'b110;
  localparam funct3_t F3And = 3'b111;
  localparam funct3_t F3Word = 3'b010;
  localparam funct3_t F3Beq = 3'b000;
  localparam funct3_t F3Bne = 3'b001;

  // Bit of funct7 that turns ADD into SUB
  localparam int F7SubBit = 5;

  // AluAdd is zero so an empty bundle adds
  typedef enum logic [2:0] {
    AluAdd = 3'd0,
    AluSub = 3'd1,
    AluAnd = 3'd2,
    AluOr = 3'd3,
    AluXor = 3'd4,
    AluSlt = 3'd5
  } aluOp_t;

endpackage

`default_nettype wire

/* hw/pipePkg.sv */
`default_nettype none

package pipePkg;

  import rvIsaPkg::*;

  typedef struct packed {
    aluOp_t aluOp;
    logic aluSrc;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic branch;
    logic branchNe;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instruction;
  } ifId_t;

  typedef struct packed {
    word_t pc;
    word_t rs1Data;
    word_t rs2Data;
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
    word_t immediate;
    ctrl_t ctrl;
  } idEx_t;

  typedef struct packed {
    word_t aluResult;
    word_t storeData;
    regIdx_t rd;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
  } exMem_t;

  // Last stage before the register file
  typedef struct packed {
    word_t memData;
    word_t aluResult;
    regIdx_t rd;
    logic memToReg;
    logic regWrite;
  } memWb_t;

endpackage

`default_nettype wire

/* hw/DecodeUnit.sv */
`default_nettype none

module DecodeUnit (
  input  var rvIsaPkg::word_t instruction,
  output pipePkg::ctrl_t ctrl,
  output rvIsaPkg::word_t immediate
);

  import rvIsaPkg::*;
  import pipePkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  aluOp_t f3Op;
  logic f3Known;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  // ALU operation shared by register and immediate forms
  always_comb begin
    f3Known = 1'b1;
    case (funct3)
      F3AddSub: f3Op = AluAdd;
      F3Slt: f3Op = AluSlt;
      F3Xor: f3Op = AluXor;
      F3Or: f3Op = AluOr;
      F3And: f3Op = AluAnd;
      default: begin
        f3Op = AluAdd;
        f3Known = 1'b0;
      end
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (opcode)
      OpReg: begin
        ctrl.regWrite = f3Known;
        ctrl.aluOp = (funct3 == F3AddSub && funct7[F7SubBit]) ? AluSub : f3Op;
      end
      OpImm: begin
        ctrl.regWrite = f3Known;
        ctrl.aluSrc = f3Known;
        ctrl.aluOp = f3Op;
      end
      OpLoad: begin
        if (funct3 == F3Word) begin
          ctrl.aluSrc = 1'b1;
          ctrl.memRead = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.regWrite = 1'b1;
        end
      end
      OpStore: begin
        if (funct3 == F3Word) begin
          ctrl.aluSrc = 1'b1;
          ctrl.memWrite = 1'b1;
        end
      end
      OpBranch: begin
        ctrl.branch = (funct3 == F3Beq) || (funct3 == F3Bne);
        ctrl.branchNe = (funct3 == F3Bne);
      end
      default: ctrl = '0;
    endcase
  end

  always_comb begin
    case (opcode)
      OpImm, OpLoad: immediate = {{20{instruction[31]}}, instruction[31:20]};
      OpStore: immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      OpBranch: immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
      default: immediate = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/RegisterFile.sv */
`default_nettype none

module RegisterFile (
  input  var logic clk,
  input  var logic rstN,
  input  var rvIsaPkg::regIdx_t rs1,
  input  var rvIsaPkg::regIdx_t rs2,
  input  var rvIsaPkg::regIdx_t writeIdx,
  input  var rvIsaPkg::word_t writeData,
  input  var logic writeEnable,
  output rvIsaPkg::word_t rs1Data,
  output rvIsaPkg::word_t rs2Data
);

  import rvIsaPkg::*;

  word_t regs [32];
  logic writeLive;

  assign writeLive = writeEnable && (writeIdx != '0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (writeLive) begin
      regs[writeIdx] <= writeData;
    end
  end

  // Write-before-read covers writeback feeding decode
  assign rs1Data = (writeLive && writeIdx == rs1) ? writeData : regs[rs1];
  assign rs2Data = (writeLive && writeIdx == rs2) ? writeData : regs[rs2];

endmodule

`default_nettype wire

/* hw/ExecuteUnit.sv */
`default_nettype none

module ExecuteUnit (
  input  var pipePkg::idEx_t stage,
  input  var rvIsaPkg::word_t memResult,
  input  var rvIsaPkg::regIdx_t memDest,
  input  var logic memRegWrite,
  input  var rvIsaPkg::word_t wbResult,
  input  var rvIsaPkg::regIdx_t wbDest,
  input  var logic wbRegWrite,
  output rvIsaPkg::word_t aluResult,
  output rvIsaPkg::word_t storeData,
  output logic takeBranch,
  output rvIsaPkg::word_t branchTarget
);

  import rvIsaPkg::*;
  import pipePkg::*;

  word_t operandA;
  word_t operandB;
  word_t aluB;
  logic operandsEqual;

  // Memory stage wins over writeback, x0 is never forwarded
  function automatic word_t forward(regIdx_t idx, word_t regValue);
    if (memRegWrite && memDest != '0 && memDest == idx) begin
      return memResult;
    end
    if (wbRegWrite && wbDest != '0 && wbDest == idx) begin
      return wbResult;
    end
    return regValue;
  endfunction

  always_comb begin
    operandA = forward(stage.rs1, stage.rs1Data);
    operandB = forward(stage.rs2, stage.rs2Data);
  end

  assign aluB = stage.ctrl.aluSrc ? stage.immediate : operandB;
  assign storeData = operandB;

  always_comb begin
    case (stage.ctrl.aluOp)
      AluAdd: aluResult = operandA + aluB;
      AluSub: aluResult = operandA - aluB;
      AluAnd: aluResult = operandA & aluB;
      AluOr: aluResult = operandA | aluB;
      AluXor: aluResult = operandA ^ aluB;
      AluSlt: aluResult = {31'b0, $signed(operandA) < $signed(aluB)};
      default: aluResult = '0;
    endcase
  end

  // Branches compare the forwarded registers, not the ALU result
  assign operandsEqual = (operandA == operandB);
  assign takeBranch = stage.ctrl.branch && (operandsEqual ^ stage.ctrl.branchNe);
  assign branchTarget = stage.pc + stage.immediate;

endmodule

`default_nettype wire

/* hw/ProgramMemory.sv */
`default_nettype none

module ProgramMemory #(
  parameter int programWords = 64
) (
  input  var logic clk,
  input  var logic progWrite,
  input  var rvIsaPkg::word_t progAddr,
  input  var rvIsaPkg::word_t progData,
  input  var rvIsaPkg::word_t fetchAddr,
  output rvIsaPkg::word_t instruction
);

  import rvIsaPkg::*;

  localparam int addrBits = $clog2(programWords);

  word_t mem [programWords];

  // Loaded from outside while the core is held in reset
  always_ff @(posedge clk) begin
    if (progWrite) begin
      mem[progAddr[addrBits+1:2]] <= progData;
    end
  end

  assign instruction = mem[fetchAddr[addrBits+1:2]];

endmodule

`default_nettype wire

/* hw/DataMemory.sv */
`default_nettype none

module DataMemory #(
  parameter int dataWords = 64
) (
  input  var logic clk,
  input  var rvIsaPkg::word_t address,
  input  var rvIsaPkg::word_t writeData,
  input  var logic write,
  output rvIsaPkg::word_t readData
);

  import rvIsaPkg::*;

  localparam int addrBits = $clog2(dataWords);

  word_t mem [dataWords];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[address[addrBits+1:2]] <= writeData;
    end
  end

  // Same-cycle read, so the memory stage never waits
  assign readData = mem[address[addrBits+1:2]];

endmodule

`default_nettype wire

/* hw/Cpu.sv */
`default_nettype none

module Cpu #(
  parameter int programWords = 64,
  parameter int dataWords = 64
) (
  input  var logic clk,
  input  var logic rstN,
  input  var logic progWrite,
  input  var rvIsaPkg::word_t progAddr,
  input  var rvIsaPkg::word_t progData,
  output logic storeValid,
  output rvIsaPkg::word_t storeAddr,
  output rvIsaPkg::word_t storeData
);

  import rvIsaPkg::*;
  import pipePkg::*;

  word_t pc;
  word_t instruction;
  ifId_t ifId;
  idEx_t idEx;
  exMem_t exMem;
  memWb_t memWb;

  regIdx_t idRs1;
  regIdx_t idRs2;
  ctrl_t decodeCtrl;
  word_t decodeImm;
  word_t rs1Data;
  word_t rs2Data;

  word_t exAluResult;
  word_t exStoreData;
  logic takeBranch;
  word_t branchTarget;
  word_t readData;
  word_t wbData;
  logic stall;

  ProgramMemory #(
    .programWords(programWords)
  ) programMemory (
    .clk(clk),
    .progWrite(progWrite),
    .progAddr(progAddr),
    .progData(progData),
    .fetchAddr(pc),
    .instruction(instruction)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (takeBranch) begin
      pc <= branchTarget;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // A cleared barrier holds instruction zero, which decodes as a no-op
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ifId <= '0;
    end else if (takeBranch) begin
      ifId <= '0;
    end else if (!stall) begin
      ifId.pc <= pc;
      ifId.instruction <= instruction;
    end
  end

  assign idRs1 = ifId.instruction[19:15];
  assign idRs2 = ifId.instruction[24:20];

  DecodeUnit decodeUnit (
    .instruction(ifId.instruction),
    .ctrl(decodeCtrl),
    .immediate(decodeImm)
  );

  RegisterFile registerFile (
    .clk(clk),
    .rstN(rstN),
    .rs1(idRs1),
    .rs2(idRs2),
    .writeIdx(memWb.rd),
    .writeData(wbData),
    .writeEnable(memWb.regWrite),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data)
  );

  // Load in execute feeding the instruction in decode
  assign stall = idEx.ctrl.memRead && (idEx.rd != '0) &&
                 ((idEx.rd == idRs1) || (idEx.rd == idRs2));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idEx <= '0;
    end else if (takeBranch) begin
      idEx <= '0;
    end else begin
      idEx.pc <= ifId.pc;
      idEx.rs1Data <= rs1Data;
      idEx.rs2Data <= rs2Data;
      idEx.rs1 <= idRs1;
      idEx.rs2 <= idRs2;
      idEx.rd <= ifId.instruction[11:7];
      idEx.immediate <= decodeImm;
      idEx.ctrl <= stall ? ctrl_t'('0) : decodeCtrl;
    end
  end

  ExecuteUnit executeUnit (
    .stage(idEx),
    .memResult(exMem.aluResult),
    .memDest(exMem.rd),
    .memRegWrite(exMem.regWrite),
    .wbResult(wbData),
    .wbDest(memWb.rd),
    .wbRegWrite(memWb.regWrite),
    .aluResult(exAluResult),
    .storeData(exStoreData),
    .takeBranch(takeBranch),
    .branchTarget(branchTarget)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMem <= '0;
    end else begin
      exMem.aluResult <= exAluResult;
      exMem.storeData <= exStoreData;
      exMem.rd <= idEx.rd;
      exMem.memRead <= idEx.ctrl.memRead;
      exMem.memWrite <= idEx.ctrl.memWrite;
      exMem.memToReg <= idEx.ctrl.memToReg;
      exMem.regWrite <= idEx.ctrl.regWrite;
    end
  end

  DataMemory #(
    .dataWords(dataWords)
  ) dataMemory (
    .clk(clk),
    .address(exMem.aluResult),
    .writeData(exMem.storeData),
    .write(exMem.memWrite),
    .readData(readData)
  );

  assign storeValid = exMem.memWrite;
  assign storeAddr = exMem.aluResult;
  assign storeData = exMem.storeData;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWb <= '0;
    end else begin
      memWb.memData <= exMem.memRead ? readData : '0;
      memWb.aluResult <= exMem.aluResult;
      memWb.rd <= exMem.rd;
      memWb.memToReg <= exMem.memToReg;
      memWb.regWrite <= exMem.regWrite;
    end
  end

  assign wbData = memWb.memToReg ? memWb.memData : memWb.aluResult;

endmodule

`default_nettype wire

/* tb/CpuBind_sva.sv */
`default_nettype none

module PipelineChecks (
  input var logic clk,
  input var logic rstN,
  input var logic stall,
  input var rvIsaPkg::word_t pc,
  input var logic storeValid,
  input var rvIsaPkg::word_t storeAddr
);

  timeunit 1ns;
  timeprecision 1ps;

  noStoreInReset: assert property (@(posedge clk) !rstN |-> !storeValid)
    else $error("storeValid high while rstN is low");

  storeAligned: assert property (@(posedge clk) disable iff (!rstN)
    storeValid |-> storeAddr[1:0] == 2'b00)
    else $error("store address not word aligned");

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  // Load-use bubble holds fetch
  pcHeldOnStall: assert property (@(posedge clk) disable iff (!rstN)
    stall |=> pc == $past(pc))
    else $error("pc moved during a stall");

endmodule

bind Cpu PipelineChecks i_pipelineChecks (
  .clk(clk),
  .rstN(rstN),
  .stall(stall),
  .pc(pc),
  .storeValid(storeValid),
  .storeAddr(storeAddr)
);

`default_nettype wire

/* tb/CpuTb.sv */
`default_nettype none

module CpuTb;

  timeunit 1ns;
  timeprecision 1ps;

  import rvIsaPkg::*;

  localparam int maxWaitCycles = 2000;
  localparam int drainCycles = 20;

  logic clk;
  logic rstN;
  logic progWrite;
  word_t progAddr;
  word_t progData;
  logic storeValid;
  word_t storeAddr;
  word_t storeData;

  word_t progAddrQ[$];
  word_t progDataQ[$];
  word_t expAddr[$];
  word_t expData[$];

  int errorCount;
  int storeCount;
  int idleCycles;
  int waitCycles;

  Cpu #(
    .programWords(64),
    .dataWords(64)
  ) i_Cpu (
    .clk(clk),
    .rstN(rstN),
    .progWrite(progWrite),
    .progAddr(progAddr),
    .progData(progData),
    .storeValid(storeValid),
    .storeAddr(storeAddr),
    .storeData(storeData)
  );

  always #50 clk = ~clk;

  // P lines hold program words, S lines the stores in program order
  task automatic loadCases();
    int fd;
    int code;
    int c;
    logic [7:0] kind;
    word_t addr;
    word_t data;
    logic done;
    fd = $fopen("tb/programCases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file tb/programCases.txt");
      errorCount++;
      return;
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        done = 1'b1;
      end else if (kind == "#") begin
        c = $fgetc(fd);
        while (c != -1 && c != 10) begin
          c = $fgetc(fd);
        end
      end else begin
        code = $fscanf(fd, "%h %h", addr, data);
        if (code != 2) begin
          $display("Malformed line in the cases file");
          errorCount++;
          done = 1'b1;
        end else if (kind == "P") begin
          progAddrQ.push_back(addr);
          progDataQ.push_back(data);
        end else if (kind == "S") begin
          expAddr.push_back(addr);
          expData.push_back(data);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic writeProgram();
    for (int i = 0; i < progAddrQ.size(); i++) begin
      @(negedge clk);
      progWrite = 1'b1;
      progAddr = progAddrQ[i];
      progData = progDataQ[i];
    end
    @(negedge clk);
    progWrite = 1'b0;
  endtask

  // Outputs settle after the rising edge, so look mid-cycle
  always @(negedge clk) begin
    if (storeValid) begin
      if (!rstN) begin
        $display("Store seen during reset at %0t", $time);
        errorCount++;
      end else if (storeCount >= expAddr.size()) begin
        $display("Unexpected extra store at %0t to address %h", $time, storeAddr);
        errorCount++;
      end else begin
        if (storeAddr !== expAddr[storeCount]) begin
          $display("Mismatch at %0t: storeAddr expected %h got %h",
                   $time, expAddr[storeCount], storeAddr);
          errorCount++;
        end
        if (storeData !== expData[storeCount]) begin
          $display("Mismatch at %0t: storeData expected %h got %h",
                   $time, expData[storeCount], storeData);
          errorCount++;
        end
        storeCount++;
      end
    end
  end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    progWrite = 1'b0;
    progAddr = '0;
    progData = '0;
    errorCount = 0;
    storeCount = 0;
    waitCycles = 0;
    void'($urandom(93));
    idleCycles = $urandom_range(3, 0);

    loadCases();
    if (expAddr.size() == 0) begin
      $display("The cases file lists no expected stores");
      errorCount++;
    end

    // Reset covers the program load, then three more cycles
    writeProgram();
    repeat (3) @(negedge clk);
    repeat (idleCycles) @(negedge clk);
    rstN = 1'b1;

    while (storeCount < expAddr.size() && waitCycles < maxWaitCycles) begin
      @(negedge clk);
      waitCycles++;
    end
    if (storeCount < expAddr.size()) begin
      $display("Timed out after %0d cycles with %0d of %0d stores seen",
               maxWaitCycles, storeCount, expAddr.size());
      errorCount++;
    end

    // Extra stores would show up here
    repeat (drainCycles) @(negedge clk);

    $display("Errors: %0d, stores checked: %0d of %0d", errorCount, storeCount, expAddr.size());
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/programCases.txt */
# P <byte address> <instruction word>
# S <byte address> <expected store data>, listed in program order
# ALU operations on x1 = 7 and x2 = -3
P 00000000 00700093
P 00000004 FFD00113
P 00000008 002081B3
P 0000000C 40208233
P 00000010 0020F2B3
P 00000014 0020E333
P 00000018 0020C3B3
P 0000001C 00112433
P 00000020 00102023
P 00000024 00302223
P 00000028 00402423
P 0000002C 00502623
P 00000030 00602823
P 00000034 00702A23
P 00000038 00802C23
# Forwarding chain at distance 1 and 2
P 0000003C 00508493
P 00000040 00948533
P 00000044 009505B3
P 00000048 00B02E23
# Load-use
P 0000004C 00402603
P 00000050 06460693
P 00000054 02D02023
# Taken BEQ skips the store at 0x5C, not-taken BNE falls through
P 00000058 00108463
P 0000005C 02102223
P 00000060 00361463
P 00000064 02202423
# Write to x0, then store x0
P 00000068 03700013
P 0000006C 02002623
# Self loop at the end
P 00000070 00000063
S 00000000 00000007
S 00000004 00000004
S 00000008 0000000A
S 0000000C 00000005
S 00000010 FFFFFFFF
S 00000014 FFFFFFFA
S 00000018 00000001
S 0000001C 00000024
S 00000020 00000068
S 00000028 FFFFFFFD
S 0000002C 00000000

/* sources.f */
hw/rvIsaPkg.sv
hw/pipePkg.sv
hw/DecodeUnit.sv
hw/RegisterFile.sv
hw/ExecuteUnit.sv
hw/ProgramMemory.sv
hw/DataMemory.sv
hw/Cpu.sv
tb/CpuBind_sva.sv
tb/CpuTb.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module CpuTb -f sources.f -o CpuTb --Mdir obj_dir

run: compile
	./obj_dir/CpuTb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
